//--- bank/bank_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module bank_tracker #(
	parameter int T_RCD = dram_pkg::T_RCD_DEF,
	parameter int T_RP  = dram_pkg::T_RP_DEF,
	parameter int T_RAS = dram_pkg::T_RAS_DEF,
	parameter int T_RC  = dram_pkg::T_RC_DEF
) (
	input  wire logic                                       clk,
	input  wire logic                                       rst_n,
	input  wire dram_pkg::dram_cmd_t                        issued,
	output dram_pkg::bank_state_t [dram_pkg::NUM_BANKS-1:0] bank_states
);
	import dram_pkg::*;

	localparam int T_MAX_1 = (T_RCD > T_RP) ? T_RCD : T_RP;
	localparam int T_MAX_2 = (T_RAS > T_RC) ? T_RAS : T_RC;
	localparam int CNT_W   = $clog2(((T_MAX_1 > T_MAX_2) ? T_MAX_1 : T_MAX_2) + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	logic prea;

	// saturating countdown
	function automatic cnt_t tick(input cnt_t c);
		return (c == '0) ? '0 : c - 1'b1;
	endfunction

	assign prea = issued.valid && (issued.op == PREA);

	// REF leaves the banks alone, PREA has closed them by then
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic hit;
		logic is_open;
		row_t open_row;
		cnt_t rcd_cnt;    // ACT to column
		cnt_t rp_cnt;     // PRE to ACT
		cnt_t ras_cnt;    // ACT to PRE
		cnt_t rc_cnt;     // ACT to ACT

		assign hit = issued.valid && (issued.bank == bank_t'(b));

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				is_open <= 1'b0;
				rcd_cnt <= '0;
				rp_cnt  <= '0;
				ras_cnt <= '0;
				rc_cnt  <= '0;
			end else begin
				rcd_cnt <= tick(rcd_cnt);
				rp_cnt  <= tick(rp_cnt);
				ras_cnt <= tick(ras_cnt);
				rc_cnt  <= tick(rc_cnt);
				if (prea || (hit && issued.op == PRE)) begin
					is_open <= 1'b0;
					rp_cnt  <= cnt_t'(T_RP - 1);
				end else if (hit && issued.op == ACT) begin
					is_open <= 1'b1;
					rcd_cnt <= cnt_t'(T_RCD - 1);
					ras_cnt <= cnt_t'(T_RAS - 1);
					rc_cnt  <= cnt_t'(T_RC - 1);
				end
			end
		end

		always_ff @(posedge clk) begin
			if (hit && issued.op == ACT)
				open_row <= issued.row;
		end

		// flags follow the counters, so they move one cycle after the command
		assign bank_states[b] = '{
			open:      is_open,
			row:       open_row,
			act_ready: !is_open && (rp_cnt == '0) && (rc_cnt == '0),
			pre_ready: (ras_cnt == '0),
			col_ready: is_open && (rcd_cnt == '0)
		};
	end

endmodule

`default_nettype wire

//--- bank/cmd_issuer.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_issuer #(
	parameter int T_CCD = dram_pkg::T_CCD_DEF
) (
	input  wire logic                                           clk,
	input  wire logic                                           rst_n,
	// head of the request queue
	input  wire dram_pkg::mem_req_t                             head,
	input  wire logic                                           head_valid,
	output logic                                                pop,
	// bank view from the tracker
	input  wire dram_pkg::bank_state_t [dram_pkg::NUM_BANKS-1:0] bank_states,
	// refresh handshake
	input  wire logic                                           ref_req,
	input  wire logic                                           ref_block,
	output logic                                                ref_done,
	output dram_pkg::dram_cmd_t                                 cmd
);
	import dram_pkg::*;

	localparam int CCD_W = $clog2(T_CCD + 1);

	bank_t            head_bank;
	row_t             head_row;
	col_t             head_col;
	bank_state_t      cur;
	logic [CCD_W-1:0] ccd_cnt;
	logic             ccd_ok;
	logic             in_seq;
	logic             any_open;
	logic             all_pre_ready;
	logic             all_act_ready;

	// row | bank | column
	assign {head_row, head_bank, head_col} = head.addr;
	assign cur    = bank_states[head_bank];
	assign ccd_ok = (ccd_cnt >= CCD_W'(T_CCD - 1));

	always_comb begin
		any_open      = 1'b0;
		all_pre_ready = 1'b1;
		all_act_ready = 1'b1;
		for (int b = 0; b < NUM_BANKS; b++) begin
			any_open      = any_open | bank_states[b].open;
			all_pre_ready = all_pre_ready & bank_states[b].pre_ready;
			all_act_ready = all_act_ready & bank_states[b].act_ready;
		end
	end

	// one command per cycle, picked from the head request or the refresh
	always_comb begin
		cmd      = '0;
		pop      = 1'b0;
		ref_done = 1'b0;
		if (!ref_block) begin
			if (ref_req && !in_seq) begin
				// refresh waits for a started sequence to finish its column command
				if (any_open) begin
					if (all_pre_ready) begin
						cmd.valid = 1'b1;
						cmd.op    = PREA;
					end
				end else if (all_act_ready) begin
					cmd.valid = 1'b1;    // tRP and tRC done in every bank
					cmd.op    = REF;
					ref_done  = 1'b1;
				end
			end else if (head_valid) begin
				cmd.bank = head_bank;
				if (cur.open && (cur.row == head_row)) begin
					// row hit, column command retires the request
					if (cur.col_ready && ccd_ok) begin
						cmd.valid = 1'b1;
						cmd.op    = head.write ? WR : RD;
						cmd.row   = head_row;
						cmd.col   = head_col;
						pop       = 1'b1;
					end
				end else if (cur.open) begin
					if (cur.pre_ready) begin
						cmd.valid = 1'b1;    // row conflict
						cmd.op    = PRE;
					end
				end else if (cur.act_ready) begin
					cmd.valid = 1'b1;
					cmd.op    = ACT;
					cmd.row   = head_row;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_seq  <= 1'b0;
			ccd_cnt <= CCD_W'(T_CCD);    // first column command may go at once
		end else begin
			if (pop)
				in_seq <= 1'b0;
			else if (cmd.valid && (cmd.op == ACT || cmd.op == PRE))
				in_seq <= 1'b1;
			// tCCD up-counter, saturates once the gap is met
			if (pop)
				ccd_cnt <= '0;
			else if (ccd_cnt != CCD_W'(T_CCD))
				ccd_cnt <= ccd_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- common/dram_pkg.sv
`default_nettype none

package dram_pkg;

	// address layout: row in the high bits, then bank, then column
	localparam int BANK_WIDTH = 2;
	localparam int ROW_WIDTH  = 4;    // kept small so row hits are common
	localparam int COL_WIDTH  = 6;
	localparam int ADDR_WIDTH = ROW_WIDTH + BANK_WIDTH + COL_WIDTH;
	localparam int NUM_BANKS  = 1 << BANK_WIDTH;

	// default timings in clk cycles
	localparam int T_RCD_DEF  = 4;
	localparam int T_RP_DEF   = 4;
	localparam int T_RAS_DEF  = 10;
	localparam int T_RC_DEF   = 14;
	localparam int T_CCD_DEF  = 2;
	localparam int T_REFI_DEF = 200;
	localparam int T_RFC_DEF  = 20;

	typedef logic [BANK_WIDTH-1:0] bank_t;
	typedef logic [ROW_WIDTH-1:0]  row_t;
	typedef logic [COL_WIDTH-1:0]  col_t;

	typedef enum logic [2:0] {
		NOP  = 3'd0,
		ACT  = 3'd1,
		PRE  = 3'd2,
		PREA = 3'd3,    // precharge all banks
		RD   = 3'd4,
		WR   = 3'd5,
		REF  = 3'd6
	} dram_cmd_e;

	// queue payload, 13 bits
	typedef struct packed {
		logic                  write;
		logic [ADDR_WIDTH-1:0] addr;
	} mem_req_t;

	// one DRAM command, 16 bits
	typedef struct packed {
		logic      valid;
		dram_cmd_e op;
		bank_t     bank;
		row_t      row;
		col_t      col;
	} dram_cmd_t;

	// per bank view for the issuer, 8 bits
	typedef struct packed {
		logic open;
		row_t row;
		logic act_ready;
		logic pre_ready;
		logic col_ready;
	} bank_state_t;

endpackage

`default_nettype wire

//--- list.f
common/dram_pkg.sv
queue/req_queue.sv
bank/bank_tracker.sv
bank/cmd_issuer.sv
src/refresh_timer.sv
src/dram_sched_top.sv
testbench/dram_sched_props.sv
testbench/tb_dram_sched.sv

//--- queue/req_queue.sv
`timescale 1ns/100ps
`default_nettype none

module req_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	// wishbone classic slave, address and direction only
	input  wire logic                            cyc,
	input  wire logic                            stb,
	input  wire logic                            we,
	input  wire logic [dram_pkg::ADDR_WIDTH-1:0] adr,
	output logic                                 ack,
	// oldest request, towards the issuer
	output dram_pkg::mem_req_t                   head,
	output logic                                 head_valid,
	input  wire logic                            pop
);
	import dram_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	mem_req_t         entries [QUEUE_DEPTH];
	mem_req_t         new_req;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             accept;

	// wraps for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(QUEUE_DEPTH));
	assign new_req = '{write: we, addr: adr};

	// ack is low for one cycle between accepts, so a held strobe counts once
	assign accept = cyc && stb && !ack && !full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack    <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			ack <= accept;    // withheld while full, master keeps waiting
			if (accept)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({accept, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // none, or push and pop together
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			entries[wr_ptr] <= new_req;
	end

	// head stays put until the issuer pops its column command
	assign head       = entries[rd_ptr];
	assign head_valid = (count != '0);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_dram_sched \
	-o sim_dram_sched > build.log 2>&1 \
	&& ./obj_dir/sim_dram_sched > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL, see build.log and sim.log"; exit 1; }

//--- src/dram_sched_top.sv
`timescale 1ns/100ps
`default_nettype none

module dram_sched_top #(
	parameter int QUEUE_DEPTH = 4,
	parameter int T_RCD       = dram_pkg::T_RCD_DEF,
	parameter int T_RP        = dram_pkg::T_RP_DEF,
	parameter int T_RAS       = dram_pkg::T_RAS_DEF,
	parameter int T_RC        = dram_pkg::T_RC_DEF,
	parameter int T_CCD       = dram_pkg::T_CCD_DEF,
	parameter int T_REFI      = dram_pkg::T_REFI_DEF,
	parameter int T_RFC       = dram_pkg::T_RFC_DEF
) (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	// wishbone classic slave, no data bus
	input  wire logic                            cyc,
	input  wire logic                            stb,
	input  wire logic                            we,
	input  wire logic [dram_pkg::ADDR_WIDTH-1:0] adr,
	output logic                                 ack,
	output dram_pkg::dram_cmd_t                  cmd
);
	import dram_pkg::*;

	mem_req_t                    head;
	logic                        head_valid;
	logic                        pop;
	bank_state_t [NUM_BANKS-1:0] bank_states;
	logic                        ref_req;
	logic                        ref_block;
	logic                        ref_done;

	req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_req_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.ack        (ack),
		.head       (head),
		.head_valid (head_valid),
		.pop        (pop)
	);

	// tracker follows the same command stream that leaves the chip
	bank_tracker #(
		.T_RCD (T_RCD),
		.T_RP  (T_RP),
		.T_RAS (T_RAS),
		.T_RC  (T_RC)
	) u_bank_tracker (
		.clk         (clk),
		.rst_n       (rst_n),
		.issued      (cmd),
		.bank_states (bank_states)
	);

	cmd_issuer #(.T_CCD(T_CCD)) u_cmd_issuer (
		.clk         (clk),
		.rst_n       (rst_n),
		.head        (head),
		.head_valid  (head_valid),
		.pop         (pop),
		.bank_states (bank_states),
		.ref_req     (ref_req),
		.ref_block   (ref_block),
		.ref_done    (ref_done),
		.cmd         (cmd)
	);

	refresh_timer #(.T_REFI(T_REFI), .T_RFC(T_RFC)) u_refresh_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.ref_done  (ref_done),
		.ref_req   (ref_req),
		.ref_block (ref_block)
	);

endmodule

`default_nettype wire

//--- src/refresh_timer.sv
`timescale 1ns/100ps
`default_nettype none

module refresh_timer #(
	parameter int T_REFI = dram_pkg::T_REFI_DEF,
	parameter int T_RFC  = dram_pkg::T_RFC_DEF
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic ref_done,     // REF went out this cycle
	output logic      ref_req,
	output logic      ref_block
);

	localparam int REFI_W = $clog2(T_REFI + 1);
	localparam int RFC_W  = $clog2(T_RFC + 1);

	logic [REFI_W-1:0] refi_cnt;
	logic [RFC_W-1:0]  rfc_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt  <= REFI_W'(T_REFI - 1);
			rfc_cnt   <= '0;
			ref_req   <= 1'b0;
			ref_block <= 1'b0;
		end else if (ref_done) begin
			// interval restarts at the REF itself
			refi_cnt  <= REFI_W'(T_REFI - 1);
			rfc_cnt   <= RFC_W'(T_RFC - 1);
			ref_req   <= 1'b0;
			ref_block <= 1'b1;
		end else begin
			if (ref_block) begin
				if (rfc_cnt == '0)
					ref_block <= 1'b0;
				else
					rfc_cnt <= rfc_cnt - 1'b1;
			end
			if (!ref_req) begin
				if (refi_cnt == '0)
					ref_req <= 1'b1;    // held until the issuer gets to REF
				else
					refi_cnt <= refi_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/dram_sched_props.sv
`timescale 1ns/100ps
`default_nettype none

module dram_sched_props #(
	parameter int T_RCD = dram_pkg::T_RCD_DEF,
	parameter int T_RP  = dram_pkg::T_RP_DEF,
	parameter int T_CCD = dram_pkg::T_CCD_DEF
) (
	input wire logic                clk,
	input wire logic                rst_n,
	input wire dram_pkg::dram_cmd_t cmd
);
	import dram_pkg::*;

	logic [7:0] since_act [NUM_BANKS];    // cycles since the last ACT, saturating
	logic [7:0] since_pre [NUM_BANKS];    // PRE or PREA
	logic [7:0] since_col;
	logic       col_cmd;

	function automatic logic [7:0] sat_inc(input logic [7:0] v);
		return (v == 8'hff) ? v : v + 8'd1;
	endfunction

	assign col_cmd = cmd.valid && (cmd.op == RD || cmd.op == WR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			since_col <= 8'hff;
			for (int b = 0; b < NUM_BANKS; b++) begin
				since_act[b] <= 8'hff;
				since_pre[b] <= 8'hff;
			end
		end else begin
			since_col <= col_cmd ? 8'd1 : sat_inc(since_col);
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (cmd.valid && cmd.op == ACT && cmd.bank == bank_t'(b))
					since_act[b] <= 8'd1;
				else
					since_act[b] <= sat_inc(since_act[b]);
				if (cmd.valid && (cmd.op == PREA || (cmd.op == PRE && cmd.bank == bank_t'(b))))
					since_pre[b] <= 8'd1;
				else
					since_pre[b] <= sat_inc(since_pre[b]);
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		col_cmd |-> since_act[cmd.bank] >= 8'(T_RCD))
		else $error("column command to bank %0d before tRCD", cmd.bank);

	assert property (@(posedge clk) disable iff (!rst_n)
		(cmd.valid && cmd.op == ACT) |-> since_pre[cmd.bank] >= 8'(T_RP))
		else $error("ACT to bank %0d before tRP", cmd.bank);

	assert property (@(posedge clk) disable iff (!rst_n)
		col_cmd |-> since_col >= 8'(T_CCD))
		else $error("column commands closer than tCCD");

endmodule

bind cmd_issuer dram_sched_props #(.T_CCD(T_CCD)) u_props (
	.clk   (clk),
	.rst_n (rst_n),
	.cmd   (cmd)
);

`default_nettype wire

//--- testbench/tb_dram_sched.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dram_sched;
	import dram_pkg::*;

	localparam int CLK_PERIOD  = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int QUEUE_DEPTH = 4;
	localparam int N_RANDOM    = 40;
	localparam int N_REQ       = 8 + 3 + 6 + N_RANDOM + 12 + 2;
	localparam int REQ_BOUND   = 40;    // cycles for a conflict plus queueing
	localparam int WATCHDOG_CYCLES = 16 + N_REQ * REQ_BOUND + T_REFI_DEF
		+ (N_REQ * REQ_BOUND / T_REFI_DEF + 2) * (T_RFC_DEF + T_RC_DEF + T_RP_DEF);

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  cyc;
	logic                  stb;
	logic                  we;
	logic [ADDR_WIDTH-1:0] adr;
	logic                  ack;
	dram_cmd_t             cmd;

	mem_req_t    pending [$];    // acked but not yet retired by RD or WR
	logic        open_v [NUM_BANKS];
	row_t        open_row [NUM_BANKS];
	logic        in_seq = 1'b0;
	int          errors = 0;
	int          n_tests = 0;
	int          n_sent = 0;
	int          n_acks = 0;
	int          n_col = 0;
	int          n_act = 0;
	int          n_pre = 0;
	int          n_prea = 0;
	int          n_ref = 0;
	int          max_occ = 0;
	int          err0;
	int          col0;
	int          act0;
	int          pre0;
	int          ref0;
	int          prea0;
	int unsigned seed_init;

	dram_sched_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.ack   (ack),
		.cmd   (cmd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic compare_values(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("mismatch at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	function automatic logic [ADDR_WIDTH-1:0] make_addr(input row_t r, input bank_t b,
		input col_t c);
		return {r, b, c};    // row | bank | column
	endfunction

	// predict the next command of the head request from the open-row table
	task automatic model_cmd(input dram_cmd_t c);
		mem_req_t  req;
		row_t      row;
		bank_t     bank;
		col_t      col;
		dram_cmd_e exp_op;
		if (c.op == PREA || c.op == REF) begin
			compare_values(int'(in_seq), 0, "refresh command inside a sequence");
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (c.op == REF)
					compare_values(int'(open_v[b]), 0, "bank still open at REF");
				open_v[b] = 1'b0;
			end
		end else if (pending.size() == 0) begin
			errors++;
			$display("error at %0d ns: command issued with no request pending", $time);
		end else begin
			req = pending[0];
			{row, bank, col} = req.addr;
			if (open_v[bank] && open_row[bank] == row)
				exp_op = req.write ? WR : RD;
			else if (open_v[bank])
				exp_op = PRE;    // conflict
			else
				exp_op = ACT;
			compare_values(int'(c.op), int'(exp_op), "command");
			compare_values(int'(c.bank), int'(bank), "bank");
			if (exp_op != PRE)
				compare_values(int'(c.row), int'(row), "row");
			if (exp_op == RD || exp_op == WR)
				compare_values(int'(c.col), int'(col), "column");
			case (exp_op)
				ACT: begin
					open_v[bank]   = 1'b1;
					open_row[bank] = row;
					in_seq         = 1'b1;
				end
				PRE: begin
					open_v[bank] = 1'b0;
					in_seq       = 1'b1;
				end
				default: begin
					pending.delete(0);
					in_seq = 1'b0;
				end
			endcase
		end
	endtask

	// ack and cmd are stable mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (ack) begin
				pending.push_back('{write: we, addr: adr});
				n_acks++;
				compare_values(int'(pending.size() <= QUEUE_DEPTH), 1, "queue within depth");
				if (pending.size() > max_occ)
					max_occ = pending.size();
			end
			if (cmd.valid) begin
				// counts come from the command stream itself
				case (cmd.op)
					ACT:     n_act++;
					PRE:     n_pre++;
					PREA:    n_prea++;
					REF:     n_ref++;
					RD, WR:  n_col++;
					default: ;
				endcase
				model_cmd(cmd);
			end
		end
	end

	// wishbone classic master that holds the request until ack
	task automatic send_request(input logic write, input logic [ADDR_WIDTH-1:0] addr,
		input int idle_max);
		int idle;
		@(posedge clk);
		#DRIVE_DELAY;
		cyc = 1'b1;
		stb = 1'b1;
		we  = write;
		adr = addr;
		n_sent++;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		@(posedge clk);
		#DRIVE_DELAY;
		cyc  = 1'b0;
		stb  = 1'b0;
		idle = $urandom_range(idle_max, 0);
		repeat (idle) @(posedge clk);
	endtask

	// kind 0 hits, 1 closed banks, 2 conflicts, 3 random, 4 burst, 5 single access
	task automatic run_set(input int kind, input int n);
		row_t  row;
		bank_t bank;
		for (int i = 0; i < n; i++) begin
			case (kind)
				0: {bank, row} = {2'd0, 4'd3};
				1: {bank, row} = {bank_t'(i + 1), 4'd7};
				2: {bank, row} = {2'd2, (i % 2 != 0) ? 4'd1 : 4'd6};
				3: begin
					bank = bank_t'($urandom_range(3, 0));
					case ($urandom_range(2, 0))
						0: row = 4'd2;
						1: row = 4'd5;
						default: row = 4'd9;
					endcase
				end
				4: {bank, row} = {2'd0, (i % 2 != 0) ? 4'd4 : 4'd11};
				default: {bank, row} = {2'd1, 4'd8};
			endcase
			send_request(1'($urandom_range(1, 0)),
				make_addr(row, bank, col_t'($urandom_range(63, 0))), (kind == 4) ? 0 : 3);
		end
		while (pending.size() != 0)
			@(posedge clk);
	endtask

	task automatic start_test();
		err0    = errors;
		col0    = n_col;
		act0    = n_act;
		pre0    = n_pre;
		ref0    = n_ref;
		prea0   = n_prea;
		max_occ = 0;
	endtask

	task automatic end_test(input string name, input int n);
		compare_values(n_col - col0, n, "RD and WR count in test");
		n_tests++;
		$display("test %0d %s: %0d requests, %0d errors", n_tests, name, n, errors - err0);
	endtask

	initial begin
		seed_init = $urandom(32'h8a394cbe);
		rst_n = 1'b0;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		for (int b = 0; b < NUM_BANKS; b++)
			open_v[b] = 1'b0;
		repeat (16) @(posedge clk);
		#DRIVE_DELAY rst_n = 1'b1;

		start_test();
		run_set(0, 8);
		compare_values(int'(n_act - act0 <= 1 + n_ref - ref0), 1, "one ACT for row hits");
		end_test("row hits", 8);

		start_test();
		run_set(1, 3);
		compare_values(n_act - act0, 3, "one ACT per closed bank");
		end_test("closed banks", 3);

		start_test();
		run_set(2, 6);
		compare_values(int'(n_pre - pre0 + n_ref - ref0 >= 6), 1, "PRE per conflict");
		end_test("row conflicts", 6);

		start_test();
		run_set(3, N_RANDOM);
		end_test("random mix", N_RANDOM);

		start_test();
		run_set(4, 12);
		compare_values(max_occ, QUEUE_DEPTH, "peak queue fill");
		end_test("back-to-back burst", 12);

		// leave bank 1 open, wait for the next REF, then touch it again
		start_test();
		run_set(5, 1);
		prea0 = n_prea;
		ref0  = n_ref;
		act0  = n_act;
		while (n_ref == ref0)
			@(posedge clk);
		compare_values(int'(n_prea > prea0), 1, "PREA before REF with a bank open");
		run_set(5, 1);
		compare_values(n_act - act0, 1, "ACT first after REF");
		end_test("refresh", 2);

		compare_values(n_acks, n_sent, "acks against requests sent");
		compare_values(n_col, n_acks, "RD and WR against acks");
		$display("%0d tests, %0d requests, %0d REF, %0d errors", n_tests, n_sent, n_ref, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
